/* source/mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// load/store buffer entries, also the initial load/store credit count.
`define LSB_DEPTH 8

// fetch queue entries, also the initial fetch credit count.
`define FETCH_DEPTH 4

// ram address width, addresses are truncated to this.
`define RAM_AWIDTH 8

// width of the tag that names an operation to the core.
`define TAG_W 3

`endif

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // memory operation kinds issued by the core.
    typedef enum logic [2:0] {
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    // one memory word, either as byte lanes (lane 0 is least significant) or whole.
    typedef union packed {
        logic [3:0][7:0] lanes;
        logic [31:0]     word;
    } mem_word_u;

    function automatic logic op_is_store(mem_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    // number of bytes moved by an operation.
    function automatic logic [2:0] op_bytes(mem_op_e op);
        logic [2:0] n;
        case (op)
            OP_LB, OP_LBU, OP_SB: n = 3'd1;
            OP_LH, OP_LHU, OP_SH: n = 3'd2;
            default:              n = 3'd4;
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

/* source/lsb_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module lsb_queue (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mem_valid,
    input  wire mem_pkg::mem_op_e  mem_op,
    input  wire logic [31:0]       mem_addr,
    input  wire logic [31:0]       mem_wdata,
    input  wire logic [`TAG_W-1:0] mem_tag,
    input  wire logic              commit,
    input  wire logic              head_take,
    output logic                   head_ready,
    output mem_pkg::mem_op_e       head_op,
    output logic [31:0]            head_addr,
    output logic [31:0]            head_wdata,
    output logic [`TAG_W-1:0]      head_tag,
    output logic                   lsb_credit
);
    import mem_pkg::*;

    localparam int PTR_W = $clog2(`LSB_DEPTH);
    localparam int CNT_W = $clog2(`LSB_DEPTH + 1);

    mem_op_e           op_mem    [`LSB_DEPTH];
    logic [31:0]       addr_mem  [`LSB_DEPTH];
    logic [31:0]       wdata_mem [`LSB_DEPTH];
    logic [`TAG_W-1:0] tag_mem   [`LSB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] committed;
    logic             pop;

    // the head may leave only after the core has committed it.
    assign head_ready = (count != '0) && (committed != '0);
    assign pop        = head_take && head_ready;
    assign lsb_credit = pop;

    assign head_op    = op_mem[head];
    assign head_addr  = addr_mem[head];
    assign head_wdata = wdata_mem[head];
    assign head_tag   = tag_mem[head];

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            op_mem[tail]    <= mem_op;
            addr_mem[tail]  <= mem_addr;
            wdata_mem[tail] <= mem_wdata;
            tag_mem[tail]   <= mem_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            committed <= '0;
        end else begin
            if (mem_valid) begin
                tail <= (tail == PTR_W'(`LSB_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(`LSB_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({mem_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // commits not yet taken by the controller.
            case ({commit, pop})
                2'b10:   committed <= committed + 1'b1;
                2'b01:   committed <= committed - 1'b1;
                default: committed <= committed;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module fetch_queue (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        fetch_valid,
    input  wire logic [31:0] fetch_pc,
    input  wire logic        fq_take,
    output logic             fq_ready,
    output logic [31:0]      fq_pc,
    output logic             fetch_credit
);

    localparam int PTR_W = $clog2(`FETCH_DEPTH);
    localparam int CNT_W = $clog2(`FETCH_DEPTH + 1);

    logic [31:0]      pc_mem [`FETCH_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign fq_ready     = (count != '0);
    assign pop          = fq_take && fq_ready;
    assign fetch_credit = pop;
    assign fq_pc        = pc_mem[head];

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc_mem[tail] <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (fetch_valid) begin
                tail <= (tail == PTR_W'(`FETCH_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(`FETCH_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({fetch_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/byte_mem_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module byte_mem_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  head_ready,
    input  wire mem_pkg::mem_op_e      head_op,
    input  wire logic [31:0]           head_addr,
    input  wire logic [31:0]           head_wdata,
    input  wire logic [`TAG_W-1:0]     head_tag,
    input  wire logic                  fq_ready,
    input  wire logic [31:0]           fq_pc,
    input  wire logic [7:0]            ram_rbyte,
    output logic                       head_take,
    output logic                       fq_take,
    output logic [`RAM_AWIDTH-1:0]     ram_addr,
    output logic                       ram_we,
    output logic [7:0]                 ram_wbyte,
    output logic                       mem_done,
    output logic [`TAG_W-1:0]          mem_tag_out,
    output logic [31:0]                mem_rdata,
    output logic                       fetch_done,
    output logic [31:0]                fetch_insn
);
    import mem_pkg::*;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_WRITE = 2'd1;
    localparam logic [1:0] S_READ  = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]             state;
    logic [2:0]             addr_cnt;
    logic [2:0]             cap_cnt;
    logic                   rd_pend;
    logic                   is_fetch;
    logic                   issue_rd;

    mem_op_e                op_q;
    logic [`TAG_W-1:0]      tag_q;
    logic [`RAM_AWIDTH-1:0] base_q;
    logic [2:0]             len_q;
    mem_word_u              data_q;

    // committed data operations win over fetches.
    assign head_take = (state == S_IDLE) && head_ready;
    assign fq_take   = (state == S_IDLE) && !head_ready && fq_ready;
    assign issue_rd  = (state == S_READ) && (addr_cnt != len_q);

    assign ram_addr  = base_q + `RAM_AWIDTH'(addr_cnt);
    assign ram_we    = (state == S_WRITE);
    assign ram_wbyte = data_q.lanes[addr_cnt[1:0]];

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= S_IDLE;
            addr_cnt <= '0;
            cap_cnt  <= '0;
            rd_pend  <= 1'b0;
            is_fetch <= 1'b0;
        end else begin
            // ram data comes back one cycle after its address.
            rd_pend <= issue_rd;
            case (state)
                S_IDLE: begin
                    addr_cnt <= '0;
                    cap_cnt  <= '0;
                    if (head_take) begin
                        is_fetch <= 1'b0;
                        state    <= op_is_store(head_op) ? S_WRITE : S_READ;
                    end else if (fq_take) begin
                        is_fetch <= 1'b1;
                        state    <= S_READ;
                    end
                end
                S_WRITE: begin
                    addr_cnt <= addr_cnt + 3'd1;
                    if (addr_cnt == len_q - 3'd1) begin
                        state <= S_DONE;
                    end
                end
                S_READ: begin
                    if (issue_rd) begin
                        addr_cnt <= addr_cnt + 3'd1;
                    end
                    if (rd_pend) begin
                        cap_cnt <= cap_cnt + 3'd1;
                        if (cap_cnt == len_q - 3'd1) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (head_take) begin
            op_q        <= head_op;
            tag_q       <= head_tag;
            base_q      <= head_addr[`RAM_AWIDTH-1:0];
            len_q       <= op_bytes(head_op);
            data_q.word <= op_is_store(head_op) ? head_wdata : 32'd0;
        end else if (fq_take) begin
            op_q        <= OP_LW;
            base_q      <= fq_pc[`RAM_AWIDTH-1:0];
            len_q       <= 3'd4;
            data_q.word <= 32'd0;
        end else if ((state == S_READ) && rd_pend) begin
            data_q.lanes[cap_cnt[1:0]] <= ram_rbyte;
        end
    end

    assign mem_done    = (state == S_DONE) && !is_fetch;
    assign fetch_done  = (state == S_DONE) && is_fetch;
    assign mem_tag_out = tag_q;
    assign fetch_insn  = data_q.word;

    // extend the assembled word by load kind, stores report zero.
    always_comb begin
        case (op_q)
            OP_LB:   mem_rdata = {{24{data_q.lanes[0][7]}}, data_q.lanes[0]};
            OP_LBU:  mem_rdata = {24'd0, data_q.lanes[0]};
            OP_LH:   mem_rdata = {{16{data_q.word[15]}}, data_q.word[15:0]};
            OP_LHU:  mem_rdata = {16'd0, data_q.word[15:0]};
            OP_LW:   mem_rdata = data_q.word;
            default: mem_rdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/byte_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module byte_ram (
    input  wire logic                   clk,
    input  wire logic [`RAM_AWIDTH-1:0] ram_addr,
    input  wire logic                   ram_we,
    input  wire logic [7:0]             ram_wbyte,
    output logic [7:0]                  ram_rbyte
);

    localparam int DEPTH = 1 << `RAM_AWIDTH;

    logic [7:0] mem [DEPTH];

    // read returns the old byte when the same address is written.
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wbyte;
        end
        ram_rbyte <= mem[ram_addr];
    end

endmodule

`default_nettype wire

/* source/mem_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mem_valid,
    input  wire mem_pkg::mem_op_e  mem_op,
    input  wire logic [31:0]       mem_addr,
    input  wire logic [31:0]       mem_wdata,
    input  wire logic [`TAG_W-1:0] mem_tag,
    input  wire logic              commit,
    output wire logic              lsb_credit,
    input  wire logic              fetch_valid,
    input  wire logic [31:0]       fetch_pc,
    output wire logic              fetch_credit,
    output wire logic              mem_done,
    output wire logic [`TAG_W-1:0] mem_tag_out,
    output wire logic [31:0]       mem_rdata,
    output wire logic              fetch_done,
    output wire logic [31:0]       fetch_insn
);
    import mem_pkg::*;

    wire logic                   head_ready;
    wire mem_op_e                head_op;
    wire logic [31:0]            head_addr;
    wire logic [31:0]            head_wdata;
    wire logic [`TAG_W-1:0]      head_tag;
    wire logic                   head_take;
    wire logic                   fq_ready;
    wire logic [31:0]            fq_pc;
    wire logic                   fq_take;
    wire logic [`RAM_AWIDTH-1:0] ram_addr;
    wire logic                   ram_we;
    wire logic [7:0]             ram_wbyte;
    wire logic [7:0]             ram_rbyte;

    lsb_queue u_lsb (
        .clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_tag(mem_tag),
        .commit(commit), .head_take(head_take), .head_ready(head_ready),
        .head_op(head_op), .head_addr(head_addr), .head_wdata(head_wdata),
        .head_tag(head_tag), .lsb_credit(lsb_credit)
    );

    fetch_queue u_fetch (
        .clk(clk), .rst(rst), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .fq_take(fq_take), .fq_ready(fq_ready), .fq_pc(fq_pc),
        .fetch_credit(fetch_credit)
    );

    byte_mem_ctrl u_ctrl (
        .clk(clk), .rst(rst), .head_ready(head_ready), .head_op(head_op),
        .head_addr(head_addr), .head_wdata(head_wdata), .head_tag(head_tag),
        .fq_ready(fq_ready), .fq_pc(fq_pc), .ram_rbyte(ram_rbyte),
        .head_take(head_take), .fq_take(fq_take), .ram_addr(ram_addr),
        .ram_we(ram_we), .ram_wbyte(ram_wbyte), .mem_done(mem_done),
        .mem_tag_out(mem_tag_out), .mem_rdata(mem_rdata),
        .fetch_done(fetch_done), .fetch_insn(fetch_insn)
    );

    byte_ram u_ram (
        .clk(clk), .ram_addr(ram_addr), .ram_we(ram_we),
        .ram_wbyte(ram_wbyte), .ram_rbyte(ram_rbyte)
    );

endmodule

`default_nettype wire

/* dv/mem_subsystem_chk.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic mem_valid,
    input wire logic fetch_valid,
    input wire logic lsb_credit,
    input wire logic fetch_credit,
    input wire logic mem_done,
    input wire logic fetch_done,
    input wire logic ram_we
);

    logic [3:0] lsb_avail;
    logic [3:0] fetch_avail;
    int         fail_count = 0;

    // credits the core still holds, rebuilt from issues and returns.
    always_ff @(posedge clk) begin
        if (!rst) begin
            lsb_avail   <= 4'(`LSB_DEPTH);
            fetch_avail <= 4'(`FETCH_DEPTH);
        end else begin
            lsb_avail   <= lsb_avail - 4'(mem_valid) + 4'(lsb_credit);
            fetch_avail <= fetch_avail - 4'(fetch_valid) + 4'(fetch_credit);
        end
    end

    a_lsb_credit: assert property (@(posedge clk) disable iff (!rst)
        mem_valid |-> lsb_avail != 4'd0)
        else begin
            $error("load/store issue with no credit left");
            fail_count++;
        end

    a_fetch_credit: assert property (@(posedge clk) disable iff (!rst)
        fetch_valid |-> fetch_avail != 4'd0)
        else begin
            $error("fetch issue with no credit left");
            fail_count++;
        end

    a_mem_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        mem_done |=> !mem_done)
        else begin
            $error("mem_done held longer than one cycle");
            fail_count++;
        end

    a_fetch_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        fetch_done |=> !fetch_done)
        else begin
            $error("fetch_done held longer than one cycle");
            fail_count++;
        end

    // the ram must not be written while in reset or right after it.
    a_we_reset: assert property (@(posedge clk) !rst |=> !ram_we)
        else begin
            $error("ram_we high out of reset");
            fail_count++;
        end

endmodule

bind mem_subsystem mem_subsystem_chk u_chk (
    .clk(clk),
    .rst(rst),
    .mem_valid(mem_valid),
    .fetch_valid(fetch_valid),
    .lsb_credit(lsb_credit),
    .fetch_credit(fetch_credit),
    .mem_done(mem_done),
    .fetch_done(fetch_done),
    .ram_we(ram_we)
);

`default_nettype wire

/* dv/mem_subsystem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem_tb;
    import mem_pkg::*;

    // ram fill, directed cases, random mix and its fetches.
    localparam int TOTAL_OPS      = 64 + 23 + 200 + 50;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 200;

    logic              clk;
    logic              rst;
    logic              mem_valid;
    mem_op_e           mem_op;
    logic [31:0]       mem_addr;
    logic [31:0]       mem_wdata;
    logic [`TAG_W-1:0] mem_tag;
    logic              commit;
    logic              fetch_valid;
    logic [31:0]       fetch_pc;
    wire logic              lsb_credit;
    wire logic              fetch_credit;
    wire logic              mem_done;
    wire logic [`TAG_W-1:0] mem_tag_out;
    wire logic [31:0]       mem_rdata;
    wire logic              fetch_done;
    wire logic [31:0]       fetch_insn;

    logic [7:0]        model [256];
    logic [31:0]       lcg_state = 32'd71;
    int                cycle;
    int                lsb_issued;
    int                lsb_returned;
    int                fetch_issued;
    int                fetch_returned;
    int                commits_sent;
    int                mem_dones;
    int                check_errors;
    int                other_errors;
    int                commit_due [$];
    logic [31:0]       exp_data [$];
    logic [`TAG_W-1:0] exp_tag [$];
    logic [31:0]       exp_insn [$];
    logic [31:0]       cur_data;
    logic [`TAG_W-1:0] cur_tag;

    mem_subsystem uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, lcg_state[31:16]};
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        hi = next_rand();
        return (hi << 16) | next_rand();
    endfunction

    // little-endian gather from the model, then extension by load kind.
    function automatic logic [31:0] expect_result(mem_op_e op, logic [31:0] addr);
        logic [7:0]  a;
        logic [31:0] w;
        a = addr[7:0];
        w = {model[a + 8'd3], model[a + 8'd2], model[a + 8'd1], model[a]};
        case (op)
            OP_LB:   return {{24{w[7]}}, w[7:0]};
            OP_LBU:  return {24'd0, w[7:0]};
            OP_LH:   return {{16{w[15]}}, w[15:0]};
            OP_LHU:  return {16'd0, w[15:0]};
            OP_LW:   return w;
            default: return 32'd0;
        endcase
    endfunction

    task automatic report_mismatch(string msg);
        check_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic report_fault(string msg);
        other_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic issue_mem(mem_op_e op, logic [31:0] addr, logic [31:0] wdata, int delay);
        int n;
        while (lsb_issued - lsb_returned >= `LSB_DEPTH) @(negedge clk);
        n = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : (op == OP_SW) ? 4 : 0;
        for (int i = 0; i < n; i++) begin
            model[addr[7:0] + 8'(i)] = wdata[8*i +: 8];
        end
        exp_data.push_back((n > 0) ? 32'd0 : expect_result(op, addr));
        exp_tag.push_back(`TAG_W'(lsb_issued));
        commit_due.push_back(cycle + delay);
        mem_valid = 1'b1;
        mem_op    = op;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_tag   = `TAG_W'(lsb_issued);
        lsb_issued++;
        @(negedge clk);
        mem_valid = 1'b0;
    endtask

    task automatic issue_fetch(logic [31:0] pc);
        while (fetch_issued - fetch_returned >= `FETCH_DEPTH) @(negedge clk);
        exp_insn.push_back(expect_result(OP_LW, pc));
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_issued++;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_data.size() != 0 || exp_insn.size() != 0) @(negedge clk);
    endtask

    // in-order commits, each one once its delay has run out.
    always @(negedge clk) begin
        if (commit_due.size() != 0 && cycle >= commit_due[0]) begin
            commit = 1'b1;
            void'(commit_due.pop_front());
            commits_sent++;
        end else begin
            commit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (lsb_credit) lsb_returned++;
        if (fetch_credit) fetch_returned++;
        if (mem_done) begin
            if (exp_data.size() == 0) begin
                report_fault("mem_done pulsed with no load or store outstanding");
            end else begin
                cur_data = exp_data.pop_front();
                cur_tag  = exp_tag.pop_front();
                assert (mem_dones < commits_sent)
                    else report_mismatch("result returned before its commit");
                assert (mem_tag_out == cur_tag)
                    else report_mismatch($sformatf("tag %0d, expected %0d", mem_tag_out, cur_tag));
                assert (mem_rdata === cur_data)
                    else report_mismatch($sformatf("tag %0d data %h, expected %h",
                                                   cur_tag, mem_rdata, cur_data));
            end
            mem_dones++;
        end
        if (fetch_done) begin
            if (exp_insn.size() == 0) begin
                report_fault("fetch_done pulsed with no fetch outstanding");
            end else begin
                cur_data = exp_insn.pop_front();
                assert (fetch_insn === cur_data)
                    else report_mismatch($sformatf("fetch %h, expected %h", fetch_insn, cur_data));
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] data;
        mem_op_e     op;
        rst         = 1'b0;
        mem_valid   = 1'b0;
        mem_op      = OP_LB;
        mem_addr    = 32'd0;
        mem_wdata   = 32'd0;
        mem_tag     = '0;
        commit      = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = 32'd0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (!mem_done && !fetch_done && !lsb_credit && !fetch_credit && !uut.ram_we)
                else report_mismatch("output active before the first issue");
        end
        // fill every byte so loads never see an unwritten location.
        for (int w = 0; w < 64; w++) begin
            issue_mem(OP_SW, 32'(4 * w), 32'h9e37_79b9 * 32'(4 * w + 1), 1);
        end
        wait_idle();
        // each store width read back by all five load kinds.
        for (int s = 0; s < 3; s++) begin
            op   = mem_op_e'(int'(OP_SB) + s);
            data = rand32() | 32'h0000_8080;
            issue_mem(op, 32'd37, data, 1 + next_rand() % 4);
            for (int l = 0; l < 5; l++) begin
                issue_mem(mem_op_e'(l), 32'd37, 32'd0, 1 + next_rand() % 4);
            end
        end
        wait_idle();
        issue_mem(OP_SW, 32'd200, rand32(), 2);
        wait_idle();
        issue_fetch(32'd200);
        wait_idle();
        // a late commit holds back the loads behind it.
        issue_mem(OP_LW, 32'd12, 32'd0, 25);
        issue_mem(OP_LHU, 32'd50, 32'd0, 1);
        issue_mem(OP_LB, 32'd99, 32'd0, 1);
        wait_idle();
        // data stays below 128 and fetches above, so fetches see no pending store.
        for (int i = 0; i < 200; i++) begin
            op = mem_op_e'(next_rand() % 8);
            issue_mem(op, next_rand() % 124, rand32(), 1 + next_rand() % 8);
            if (i % 4 == 3) issue_fetch(32'd128 + next_rand() % 125);
        end
        wait_idle();
        repeat (4) @(negedge clk);
        assert (lsb_returned == lsb_issued)
            else report_mismatch($sformatf("%0d lsb credits back for %0d issued",
                                           lsb_returned, lsb_issued));
        assert (fetch_returned == fetch_issued)
            else report_mismatch($sformatf("%0d fetch credits back for %0d issued",
                                           fetch_returned, fetch_issued));
        // protocol assertions in the bound checker count as other failures.
        other_errors += uut.u_chk.fail_count;
        $display("errors: %0d check failures, %0d other failures", check_errors, other_errors);
        if (check_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/mem_pkg.sv
source/lsb_queue.sv
source/fetch_queue.sv
source/byte_mem_ctrl.sv
source/byte_ram.sv
source/mem_subsystem.sv
dv/mem_subsystem_chk.sv
dv/mem_subsystem_tb.sv
